/* crc24_pkg.sv */
package crc24_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	// every beat carries one data word of this many bits
	localparam int word_bits = 64;

	// remainder width of the interlaken style crc
	localparam int crc_bits = 24;

	////////////////////////////////////////
	// types
	////////////////////////////////////////

	// running remainder and per word contribution share this type
	typedef logic [crc_bits-1:0] crc_t;

	// one input beat, data first and the framing flags below it
	// sop marks the first word of a packet, eop the last one
	// a single word packet has both flags set on the same beat
	typedef struct packed {
		logic [word_bits-1:0] data;
		logic                 sop;
		logic                 eop;
	} beat_t;

	////////////////////////////////////////
	// polynomial and start value
	////////////////////////////////////////

	// generator 0x328b63 with the implied x^24 term dropped
	// the register shifts left, msb out, and xors this in when
	// the bit shifted out differs from the incoming data bit
	localparam crc_t crc24_poly = 24'h328b63;

	// every packet starts from all ones
	// the remainder is handed out as is, with no final inversion
	localparam crc_t crc24_init = 24'hffffff;

endpackage

/* crc24_word_contrib.sv */
module crc24_word_contrib import crc24_pkg::*; (
	input  logic [word_bits-1:0] data,
	output crc_t                 contrib
);

	////////////////////////////////////////
	// evolved data word
	////////////////////////////////////////

	// the crc is linear over gf(2), so the remainder of a packet is the
	// xor of what each word adds on its own plus what the earlier state
	// becomes after 64 more bit times
	// this block produces the first part, the word run from a zero start

	// the loop below is just the bit serial register unrolled
	// synthesis turns it into a flat xor network, each output bit being
	// the parity of a fixed subset of the 64 data bits

	always_comb begin : serial_unroll
		crc_t r;
		logic fb;

		// zero start, so only the data bits drive the result
		r = '0;

		// most significant data bit enters first
		for (int i = word_bits - 1; i >= 0; i--) begin
			// feedback is the bit leaving the top xor the new data bit
			fb = r[$bits(crc_t)-1] ^ data[i];
			r = {r[$bits(crc_t)-2:0], 1'b0};
			if (fb) begin
				r = r ^ crc24_poly;
			end
		end

		contrib = r;
	end

	// the contribution alone is not a crc of anything useful
	// it only becomes one after being xored with the advanced state
	// of whatever came before the word, see crc24_combine

endmodule

/* crc24_zero_advance.sv */
module crc24_zero_advance import crc24_pkg::*; #(
	parameter int zero_bits = word_bits
) (
	input  crc_t rem_in,
	output crc_t rem_out
);

	////////////////////////////////////////
	// advance past zero data
	////////////////////////////////////////

	// clocking the serial register with zero data bits only leaves the
	// feedback term, so the result is a fixed linear map of rem_in
	// with a constant input the whole thing folds down to a constant

	always_comb begin : zero_unroll
		crc_t r;
		logic fb;

		r = rem_in;

		for (int i = 0; i < zero_bits; i++) begin
			// data bit is zero, so the feedback is just the top bit
			fb = r[$bits(crc_t)-1];
			r = {r[$bits(crc_t)-2:0], 1'b0};
			if (fb) begin
				r = r ^ crc24_poly;
			end
		end

		rem_out = r;
	end

	// zero_bits is normally one word, which moves a remainder from the
	// end of one word to the end of the next when combined with the
	// evolved data of that next word

endmodule

/* crc24_combine.sv */
module crc24_combine import crc24_pkg::*; #(
	parameter int zero_bits = word_bits
) (
	input  logic  clk,
	input  logic  arst,
	input  logic  s_valid,
	output logic  s_ready,
	input  beat_t s_beat,
	output logic  r_valid,
	input  logic  r_ready,
	output crc_t  r_crc
);

	// single enable for both stages
	// it drops only while a finished remainder waits at the output
	logic en;

	crc_t contrib;
	crc_t adv_init;
	crc_t adv_rem;

	// stage one registers
	crc_t contrib_q;
	logic first_q;
	logic last_q;
	logic stg_valid;

	// stage two running remainder
	crc_t rem_q;

	assign en      = ~(r_valid & ~r_ready);
	assign s_ready = en;

	////////////////////////////////////////
	// contributions
	////////////////////////////////////////

	// evolved data word of the incoming beat
	crc24_word_contrib u_contrib (
		.data    (s_beat.data),
		.contrib (contrib)
	);

	// start value pushed past one word, this is a constant
	crc24_zero_advance #(.zero_bits(zero_bits)) u_adv_init (
		.rem_in  (crc24_init),
		.rem_out (adv_init)
	);

	// running remainder pushed past one word, the feedback path
	crc24_zero_advance #(.zero_bits(zero_bits)) u_adv_rem (
		.rem_in  (rem_q),
		.rem_out (adv_rem)
	);

	////////////////////////////////////////
	// stage one
	////////////////////////////////////////

	// register the contribution so it lines up with the remainder
	// that stage two selects one cycle later
	always_ff @(posedge clk) begin
		if (en) begin
			contrib_q <= contrib;
		end
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			stg_valid <= 1'b0;
			first_q   <= 1'b0;
			last_q    <= 1'b0;
		end else if (en) begin
			stg_valid <= s_valid;
			first_q   <= s_beat.sop;
			last_q    <= s_beat.eop;
		end
	end

	////////////////////////////////////////
	// stage two
	////////////////////////////////////////

	// a first word folds in the evolved start value, any later word
	// folds in the evolved remainder of the word before it
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			rem_q   <= crc24_init;
			r_valid <= 1'b0;
		end else if (en) begin
			if (stg_valid) begin
				rem_q <= contrib_q ^ (first_q ? adv_init : adv_rem);
			end
			// presented once, on the last word of a packet
			r_valid <= stg_valid & last_q;
		end
	end

	assign r_crc = rem_q;

endmodule

/* crc24_skid.sv */
module crc24_skid #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     arst,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_payload,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_payload
);

	// main entry faces the output, the spare catches the one beat
	// that may arrive while the output is stalled
	payload_t main_q;
	payload_t spare_q;
	logic     main_valid;
	logic     spare_valid;

	logic in_fire;
	logic out_fire;
	logic main_free;
	logic main_from_spare;
	logic main_from_in;
	logic spare_load;

	// ready comes straight from a flop, no path from out_ready
	assign in_ready    = ~spare_valid;
	assign out_valid   = main_valid;
	assign out_payload = main_q;

	assign in_fire  = in_valid & in_ready;
	assign out_fire = main_valid & out_ready;

	// main slot is open next cycle if empty now or being drained
	assign main_free       = ~main_valid | out_fire;
	assign main_from_spare = main_free & spare_valid;
	assign main_from_in    = main_free & ~spare_valid & in_fire;
	assign spare_load      = ~main_free & in_fire;

	////////////////////////////////////////
	// occupancy
	////////////////////////////////////////

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			main_valid  <= 1'b0;
			spare_valid <= 1'b0;
		end else begin
			if (main_free) begin
				main_valid <= spare_valid | in_fire;
			end
			// spare empties as soon as main can take it
			if (main_from_spare) begin
				spare_valid <= 1'b0;
			end else if (spare_load) begin
				spare_valid <= 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// payload
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (main_from_spare) begin
			main_q <= spare_q;
		end else if (main_from_in) begin
			main_q <= in_payload;
		end
		if (spare_load) begin
			spare_q <= in_payload;
		end
	end

endmodule

/* crc24_stream_top.sv */
module crc24_stream_top import crc24_pkg::*; #(
	parameter int zero_bits = word_bits
) (
	input  logic                 clk,
	input  logic                 arst,
	input  logic                 in_valid,
	output logic                 in_ready,
	input  logic [word_bits-1:0] in_data,
	input  logic                 in_sop,
	input  logic                 in_eop,
	output logic                 crc_valid,
	input  logic                 crc_ready,
	output crc_t                 crc
);

	beat_t in_beat;

	// input skid to combine pipeline
	logic  s_valid;
	logic  s_ready;
	beat_t s_beat;

	// combine pipeline to output skid
	logic r_valid;
	logic r_ready;
	crc_t r_crc;

	// pack the flat input ports into one beat
	assign in_beat.data = in_data;
	assign in_beat.sop  = in_sop;
	assign in_beat.eop  = in_eop;

	////////////////////////////////////////
	// datapath
	////////////////////////////////////////

	// input skid keeps in_ready off the combine enable path
	crc24_skid #(.payload_t(beat_t)) u_in_skid (
		.clk         (clk),
		.arst        (arst),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.in_payload  (in_beat),
		.out_valid   (s_valid),
		.out_ready   (s_ready),
		.out_payload (s_beat)
	);

	crc24_combine #(.zero_bits(zero_bits)) u_combine (
		.clk     (clk),
		.arst    (arst),
		.s_valid (s_valid),
		.s_ready (s_ready),
		.s_beat  (s_beat),
		.r_valid (r_valid),
		.r_ready (r_ready),
		.r_crc   (r_crc)
	);

	// output skid decouples crc_ready from the combine enable
	crc24_skid #(.payload_t(crc_t)) u_out_skid (
		.clk         (clk),
		.arst        (arst),
		.in_valid    (r_valid),
		.in_ready    (r_ready),
		.in_payload  (r_crc),
		.out_valid   (crc_valid),
		.out_ready   (crc_ready),
		.out_payload (crc)
	);

endmodule

/* crc24_tb_asserts.sv */
module crc24_tb_asserts (
	input logic        clk,
	input logic        arst,
	input logic        in_valid,
	input logic        in_ready,
	input logic [63:0] in_data,
	input logic        in_sop,
	input logic        in_eop,
	input logic        crc_valid,
	input logic        crc_ready,
	input logic [23:0] crc
);

	////////////////////////////////////////
	// handshake rules
	////////////////////////////////////////

	// an offered beat stays put until the top level takes it
	in_hold : assert property (@(posedge clk) disable iff (arst)
		in_valid && !in_ready |=> in_valid && $stable({in_data, in_sop, in_eop}))
		else $error("input beat changed before its transfer");

	// a remainder waiting on crc_ready must neither vanish nor change
	crc_hold : assert property (@(posedge clk) disable iff (arst)
		crc_valid && !crc_ready |=> crc_valid && $stable(crc))
		else $error("crc output changed while stalled");

	////////////////////////////////////////
	// reset values
	////////////////////////////////////////

	// the reset is asynchronous, so by any edge inside it both skids are empty
	rst_vals : assert property (@(posedge clk)
		arst |-> !crc_valid && in_ready)
		else $error("handshake outputs wrong during reset");

endmodule

/* crc24_tb.sv */
module crc24_tb;

	// crc definition restated for the reference model
	localparam logic [23:0] ref_poly = 24'h328b63;
	localparam logic [23:0] ref_init = 24'hffffff;

	// one row per packet with its length in words, gap and stall odds in percent
	// and whether a reset lands before its remainder comes out
	typedef struct packed {
		int   len;
		int   gap_pct;
		int   stall_pct;
		logic abort_rst;
	} row_t;

	localparam int n_rows = 14;
	localparam row_t test_rows [n_rows] = '{
		'{1, 0, 0, 1'b0},
		'{2, 0, 0, 1'b0},
		'{5, 0, 0, 1'b0},
		'{16, 0, 0, 1'b0},
		'{7, 40, 0, 1'b0},
		'{3, 60, 0, 1'b0},
		'{4, 0, 60, 1'b0},
		'{1, 0, 70, 1'b0},
		'{1, 0, 70, 1'b0},
		'{1, 0, 70, 1'b0},
		'{9, 30, 50, 1'b0},
		'{3, 0, 0, 1'b1},
		'{6, 20, 30, 1'b0},
		'{1, 0, 0, 1'b0}
	};

	logic        clk = 1'b0;
	logic        arst;
	logic        in_valid;
	logic        in_ready;
	logic [63:0] in_data;
	logic        in_sop;
	logic        in_eop;
	logic        crc_valid;
	logic        crc_ready;
	logic [23:0] crc;

	integer      seed = 18;
	integer      stall_seed = 18 ^ 32'h5a5a;
	int          stall_pct = 0;
	int          errors = 0;
	int          sent = 0;
	int          rcvd = 0;
	logic [23:0] exp_q [$];

	crc24_stream_top u_dut (
		.clk       (clk),
		.arst      (arst),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.in_sop    (in_sop),
		.in_eop    (in_eop),
		.crc_valid (crc_valid),
		.crc_ready (crc_ready),
		.crc       (crc)
	);

	bind crc24_stream_top crc24_tb_asserts u_asserts (.*);

	always #50 clk = ~clk;

	////////////////////////////////////////
	// reference model and checks
	////////////////////////////////////////

	// bit serial register fed with the msb of the word first
	function automatic logic [23:0] serial_fold(input logic [23:0] rem, input logic [63:0] word);
		logic [23:0] r;
		logic        fb;
		r = rem;
		for (int i = 63; i >= 0; i--) begin
			fb = r[23] ^ word[i];
			r = {r[22:0], 1'b0};
			if (fb) begin
				r = r ^ ref_poly;
			end
		end
		return r;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	function automatic int total_words();
		int n;
		n = 0;
		for (int i = 0; i < n_rows; i++) begin
			n += test_rows[i].len;
		end
		return n;
	endfunction

	// called a little after a rising edge, returns at the same point
	// of the edge after the transfer
	task automatic send_beat(input logic [63:0] data, input logic sop, input logic eop);
		in_valid = 1'b1;
		in_data  = data;
		in_sop   = sop;
		in_eop   = eop;
		// in_ready only moves on a rising edge, so the falling edge is safe
		@(negedge clk);
		while (!in_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic insert_gaps(input int pct);
		int r;
		r = $random(seed);
		while (((r & 32'h7fffffff) % 100) < pct) begin
			in_valid = 1'b0;
			@(posedge clk);
			#1;
			r = $random(seed);
		end
	endtask

	task automatic pulse_reset();
		arst = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		arst = 1'b0;
		// the start of a packet needs an empty pipe and an open input
		check_val("in_ready", 32'(in_ready), 32'h1);
		check_val("crc_valid", 32'(crc_valid), 32'h0);
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
		#1;
	endtask

	////////////////////////////////////////
	// receive side
	////////////////////////////////////////

	initial begin : receive
		int          r;
		logic [23:0] exp;
		crc_ready = 1'b1;
		forever begin
			@(negedge clk);
			if (crc_valid && crc_ready) begin
				if (exp_q.size() == 0) begin
					$display("remainder %h arrived with no packet outstanding", crc);
					errors++;
				end else begin
					exp = exp_q.pop_front();
					check_val("crc", 32'(crc), 32'(exp));
				end
				rcvd++;
			end
			@(posedge clk);
			#1;
			r = $random(stall_seed);
			crc_ready = ((r & 32'h7fffffff) % 100) >= stall_pct;
		end
	end

	////////////////////////////////////////
	// send side and table loop
	////////////////////////////////////////

	initial begin : stimulus
		logic [23:0] rem;
		logic [63:0] words [$];
		row_t        row;
		arst     = 1'b0;
		in_valid = 1'b0;
		in_data  = '0;
		in_sop   = 1'b0;
		in_eop   = 1'b0;
		@(posedge clk);
		#1;
		pulse_reset();

		for (int k = 0; k < n_rows; k++) begin
			row = test_rows[k];
			stall_pct = row.stall_pct;
			// an aborted packet starts only once earlier results are out
			if (row.abort_rst) begin
				wait_drain();
			end
			words.delete();
			rem = ref_init;
			for (int w = 0; w < row.len; w++) begin
				words.push_back({$random(seed), $random(seed)});
				rem = serial_fold(rem, words[w]);
			end
			if (!row.abort_rst) begin
				exp_q.push_back(rem);
				sent++;
			end
			for (int w = 0; w < row.len; w++) begin
				insert_gaps(row.gap_pct);
				send_beat(words[w], w == 0, w == row.len - 1);
			end
			// reset while the remainder of this packet is still in the pipe
			if (row.abort_rst) begin
				pulse_reset();
			end
		end

		stall_pct = 0;
		wait_drain();
		check_val("packets received", 32'(rcvd), 32'(sent));
		$display("errors %0d, packets sent %0d, received %0d", errors, sent, rcvd);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// worst case gaps and stalls stay well under twenty cycles a word
	initial begin : watchdog
		int limit;
		limit = total_words() * 20 + 200;
		repeat (limit) @(posedge clk);
		$display("timeout, the run did not finish within %0d clock cycles", limit);
		$display("tests failed");
		$finish;
	end

endmodule

/* vlog.f */
crc24_pkg.sv
crc24_word_contrib.sv
crc24_zero_advance.sv
crc24_combine.sv
crc24_skid.sv
crc24_stream_top.sv
crc24_tb_asserts.sv
crc24_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module crc24_tb -f vlog.f -o crc24_sim

# a failing assertion may stop the simulator early, the log decides below
./obj_dir/crc24_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi

if ! grep -q "all tests passed" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi

echo "simulation passed"
